/* verilog/video_pkg.sv */
`default_nettype none

package video_pkg;

    // coordinate width, shared by both counters
    localparam int unsigned coord_w = 12;

    typedef logic [coord_w-1:0] coord_t;

    // 800x600 at 72 Hz, 50 MHz pixel clock
    localparam coord_t h_active     = 12'd800;
    localparam coord_t h_sync_start = 12'd856;
    localparam coord_t h_sync_end   = 12'd976;
    localparam coord_t h_total      = 12'd1040;

    localparam coord_t v_active     = 12'd600;
    localparam coord_t v_sync_start = 12'd637;
    localparam coord_t v_sync_end   = 12'd643;
    localparam coord_t v_total      = 12'd666;

    // both syncs positive for this mode
    localparam logic sync_active_high = 1'b1;

    // playfield window, bounds inclusive
    localparam coord_t win_x_min = 12'd40;
    localparam coord_t win_x_max = 12'd760;
    localparam coord_t win_y_min = 12'd30;
    localparam coord_t win_y_max = 12'd570;

    // game pixel: r in [11:8], g in [7:4], b in [3:0]
    typedef logic [11:0] rgb444_t;

    // output pixel: r in [23:16], g in [15:8], b in [7:0]
    typedef logic [23:0] rgb888_t;

    // coordinate to output pixel, in video_clk cycles
    //   one cycle in pixel_compose
    //   one cycle in video_out
    localparam int unsigned pipe_latency = 2;

endpackage

`default_nettype wire

/* verilog/video_timing.sv */
`default_nettype none

module video_timing (
    input  wire             video_clk,
    input  wire             btn_rst,
    output video_pkg::coord_t hdata_o,
    output video_pkg::coord_t vdata_o,
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            de_o
);

    import video_pkg::*;

    // last count of each counter before it wraps
    localparam coord_t h_last = h_total - 12'd1;
    localparam coord_t v_last = v_total - 12'd1;

    coord_t h_cnt;
    coord_t v_cnt;
    logic   h_wrap;
    logic   v_wrap;
    logic   in_hsync;
    logic   in_vsync;

    assign h_wrap = (h_cnt == h_last);
    assign v_wrap = (v_cnt == v_last);

    // pixel counter, runs every cycle
    always_ff @(posedge video_clk) begin
        if (btn_rst) begin
            h_cnt <= '0;
        end else if (h_wrap) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + 12'd1;
        end
    end

    // line counter steps at end of each line
    always_ff @(posedge video_clk) begin
        if (btn_rst) begin
            v_cnt <= '0;
        end else if (h_wrap) begin
            if (v_wrap) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 12'd1;
            end
        end
    end

    // decodes straight off the counters
    always_comb begin
        in_hsync = (h_cnt >= h_sync_start) && (h_cnt < h_sync_end);
        in_vsync = (v_cnt >= v_sync_start) && (v_cnt < v_sync_end);
    end

    always_comb begin
        if (in_hsync) begin
            hsync_o = sync_active_high;
        end else begin
            hsync_o = ~sync_active_high;
        end
        if (in_vsync) begin
            vsync_o = sync_active_high;
        end else begin
            vsync_o = ~sync_active_high;
        end
    end

    assign de_o = (h_cnt < h_active) && (v_cnt < v_active); // visible area only

    assign hdata_o = h_cnt;
    assign vdata_o = v_cnt;

endmodule

`default_nettype wire

/* verilog/pixel_compose.sv */
`default_nettype none

module pixel_compose (
    input  wire                video_clk,
    input  wire                btn_rst,
    input  video_pkg::coord_t  hdata_i,
    input  video_pkg::coord_t  vdata_i,
    input  wire                start_i,
    input  wire                to_black_i,
    input  video_pkg::rgb444_t game_pixel_i,
    input  video_pkg::rgb888_t splash_pixel_i,
    output video_pkg::rgb888_t rgb_o
);

    import video_pkg::*;

    logic    game_mode;  // 0 splash, 1 game
    logic    in_window;
    logic    force_black;
    rgb888_t game_wide;
    rgb888_t pixel_next;

    // sticky until reset; position in the start cycle is still splash
    always_ff @(posedge video_clk) begin
        if (btn_rst) begin
            game_mode <= 1'b0;
        end else if (start_i) begin
            game_mode <= 1'b1;
        end
    end

    // playfield window, inclusive bounds
    always_comb begin
        in_window = (hdata_i >= win_x_min) && (hdata_i <= win_x_max)
                 && (vdata_i >= win_y_min) && (vdata_i <= win_y_max);
    end

    assign force_black = !in_window || to_black_i;

    // nibble repeat, 4'ha becomes 8'haa
    always_comb begin
        game_wide = {game_pixel_i[11:8], game_pixel_i[11:8],
                     game_pixel_i[7:4],  game_pixel_i[7:4],
                     game_pixel_i[3:0],  game_pixel_i[3:0]};
    end

    // source select
    always_comb begin
        if (!game_mode) begin
            pixel_next = splash_pixel_i;  // splash image covers the whole screen
        end else if (force_black) begin
            pixel_next = '0;
        end else begin
            pixel_next = game_wide;
        end
    end

    always_ff @(posedge video_clk) begin
        rgb_o <= pixel_next;
    end

endmodule

`default_nettype wire

/* verilog/video_out.sv */
`default_nettype none

module video_out (
    input  wire                video_clk,
    input  wire                btn_rst,
    input  video_pkg::rgb888_t rgb_i,
    input  wire                hsync_i,
    input  wire                vsync_i,
    input  wire                de_i,
    output video_pkg::rgb888_t rgb_o,
    output logic               hsync_o,
    output logic               vsync_o,
    output logic               de_o
);

    import video_pkg::*;

    // {hsync, vsync, de} per stage
    localparam int unsigned ctrl_w = 3;

    logic [ctrl_w-1:0] ctrl_q [pipe_latency];
    logic              de_aligned;

    // control follows the pixel through the whole pipe
    always_ff @(posedge video_clk) begin
        if (btn_rst) begin
            for (int i = 0; i < pipe_latency; i++) begin
                ctrl_q[i] <= '0;
            end
        end else begin
            ctrl_q[0] <= {hsync_i, vsync_i, de_i};
            for (int i = 1; i < pipe_latency; i++) begin
                ctrl_q[i] <= ctrl_q[i-1];
            end
        end
    end

    // enable that belongs to the pixel now on rgb_i
    assign de_aligned = ctrl_q[pipe_latency-2][0];

    always_ff @(posedge video_clk) begin
        if (btn_rst) begin
            rgb_o <= '0;
        end else if (de_aligned) begin
            rgb_o <= rgb_i;
        end else begin
            rgb_o <= '0;  // blanking is black
        end
    end

    assign {hsync_o, vsync_o, de_o} = ctrl_q[pipe_latency-1];

endmodule

`default_nettype wire

/* verilog/video_top.sv */
`default_nettype none

module video_top (
    input  wire                video_clk,
    input  wire                btn_rst,
    input  wire                start_i,
    input  wire                to_black_i,
    input  video_pkg::rgb444_t game_pixel_i,
    input  video_pkg::rgb888_t splash_pixel_i,
    output video_pkg::coord_t  hdata_o,
    output video_pkg::coord_t  vdata_o,
    output video_pkg::rgb888_t rgb_o,
    output logic               de_o,
    output logic               hsync_o,
    output logic               vsync_o
);

    import video_pkg::*;

    coord_t  hdata;
    coord_t  vdata;
    logic    hsync_raw;
    logic    vsync_raw;
    logic    de_raw;
    rgb888_t rgb_comp;

    // raster generator
    video_timing u_timing (
        .video_clk (video_clk),
        .btn_rst   (btn_rst),
        .hdata_o   (hdata),
        .vdata_o   (vdata),
        .hsync_o   (hsync_raw),
        .vsync_o   (vsync_raw),
        .de_o      (de_raw)
    );

    pixel_compose u_compose (
        .video_clk      (video_clk),
        .btn_rst        (btn_rst),
        .hdata_i        (hdata),
        .vdata_i        (vdata),
        .start_i        (start_i),
        .to_black_i     (to_black_i),
        .game_pixel_i   (game_pixel_i),
        .splash_pixel_i (splash_pixel_i),
        .rgb_o          (rgb_comp)
    );

    video_out u_out (
        .video_clk (video_clk),
        .btn_rst   (btn_rst),
        .rgb_i     (rgb_comp),
        .hsync_i   (hsync_raw),
        .vsync_i   (vsync_raw),
        .de_i      (de_raw),
        .rgb_o     (rgb_o),
        .hsync_o   (hsync_o),
        .vsync_o   (vsync_o),
        .de_o      (de_o)
    );

    // frame and splash sources look up their pixel from these
    assign hdata_o = hdata;
    assign vdata_o = vdata;

endmodule

`default_nettype wire

/* sim/video_top_asserts.sv */
`default_nettype none

module video_top_asserts (
    input wire                video_clk,
    input wire                btn_rst,
    input wire                start_i,
    input wire                to_black_i,
    input video_pkg::rgb444_t game_pixel_i,
    input video_pkg::rgb888_t splash_pixel_i,
    input video_pkg::coord_t  hdata_i,
    input video_pkg::coord_t  vdata_i,
    input video_pkg::rgb888_t rgb_i,
    input wire                de_i,
    input wire                hsync_i,
    input wire                vsync_i
);
    timeunit 1ns;
    timeprecision 1ps;

    import video_pkg::*;

    localparam int unsigned hs_high = int'(h_sync_end) - int'(h_sync_start);
    localparam int unsigned hs_low  = int'(h_total) - hs_high;
    localparam int unsigned vs_high = (int'(v_sync_end) - int'(v_sync_start)) * int'(h_total);
    localparam int unsigned vs_low  = int'(h_total) * int'(v_total) - vs_high;

    logic        failed = 1'b0;  // read by the testbench
    logic        mode_q;         // expected splash/game bit
    logic        rst_q;
    logic        ok_q [2];
    coord_t      h_q [2];
    coord_t      v_q [2];
    logic        blk_q [2];
    logic        game_q [2];
    rgb444_t     gpx_q [2];
    rgb888_t     spx_q [2];
    logic        in_win2;
    rgb888_t     wide2;
    logic [2:0]  lvl;            // {de, vsync, hsync}, 1 = active
    logic [2:0]  lvl_q;
    logic [2:0]  full;           // run started at a seen edge
    int unsigned run_len [3];

    // two positions in flight, index 1 is the one on the outputs now
    always_ff @(posedge video_clk) begin
        rst_q <= btn_rst;
        if (btn_rst) begin
            mode_q  <= 1'b0;
            ok_q[0] <= 1'b0;
            ok_q[1] <= 1'b0;
        end else begin
            if (start_i) begin
                mode_q <= 1'b1;
            end
            ok_q[0] <= 1'b1;
            ok_q[1] <= ok_q[0];
        end
        h_q[0]    <= hdata_i;
        h_q[1]    <= h_q[0];
        v_q[0]    <= vdata_i;
        v_q[1]    <= v_q[0];
        blk_q[0]  <= to_black_i;
        blk_q[1]  <= blk_q[0];
        game_q[0] <= mode_q;  // mode before this edge
        game_q[1] <= game_q[0];
        gpx_q[0]  <= game_pixel_i;
        gpx_q[1]  <= gpx_q[0];
        spx_q[0]  <= splash_pixel_i;
        spx_q[1]  <= spx_q[0];
    end

    always_comb begin
        in_win2 = (h_q[1] >= win_x_min) && (h_q[1] <= win_x_max)
               && (v_q[1] >= win_y_min) && (v_q[1] <= win_y_max);
        wide2 = {gpx_q[1][11:8], gpx_q[1][11:8], gpx_q[1][7:4], gpx_q[1][7:4],
                 gpx_q[1][3:0], gpx_q[1][3:0]};
    end

    assign lvl = {de_i, vsync_i == sync_active_high, hsync_i == sync_active_high};

    // run lengths of each control level
    always_ff @(posedge video_clk) begin
        if (btn_rst) begin
            lvl_q <= '0;
            full  <= '0;
            for (int i = 0; i < 3; i++) begin
                run_len[i] <= 0;
            end
        end else begin
            lvl_q <= lvl;
            for (int i = 0; i < 3; i++) begin
                if (lvl[i] != lvl_q[i]) begin
                    run_len[i] <= 1;
                    full[i]    <= 1'b1;
                end else begin
                    run_len[i] <= run_len[i] + 1;
                end
            end
        end
    end

    assert property (@(posedge video_clk) disable iff (btn_rst)
        (full[0] && lvl[0] != lvl_q[0]) |-> run_len[0] == (lvl_q[0] ? hs_high : hs_low))
    else begin
        $error("[FAIL] %0t hsync run of %0d cycles", $time, $sampled(run_len[0]));
        failed = 1'b1;
    end

    // a stuck hsync shows no edge at all
    assert property (@(posedge video_clk) disable iff (btn_rst)
        run_len[0] <= (lvl_q[0] ? hs_high : hs_low))
    else begin
        $error("[FAIL] %0t hsync held for %0d cycles", $time, $sampled(run_len[0]));
        failed = 1'b1;
    end

    assert property (@(posedge video_clk) disable iff (btn_rst)
        (full[1] && lvl[1] != lvl_q[1]) |-> run_len[1] == (lvl_q[1] ? vs_high : vs_low))
    else begin
        $error("[FAIL] %0t vsync run of %0d cycles", $time, $sampled(run_len[1]));
        failed = 1'b1;
    end

    assert property (@(posedge video_clk) disable iff (btn_rst)
        (full[2] && lvl_q[2] && !lvl[2]) |-> run_len[2] == int'(h_active))
    else begin
        $error("[FAIL] %0t de high for %0d cycles", $time, $sampled(run_len[2]));
        failed = 1'b1;
    end

    assert property (@(posedge video_clk) disable iff (btn_rst)
        (ok_q[1] && v_q[1] >= v_active) |-> !de_i)
    else begin
        $error("[FAIL] %0t de high on line %0d", $time, $sampled(v_q[1]));
        failed = 1'b1;
    end

    assert property (@(posedge video_clk) disable iff (btn_rst)
        !de_i |-> rgb_i == '0)
    else begin
        $error("[FAIL] %0t rgb %h during blanking", $time, $sampled(rgb_i));
        failed = 1'b1;
    end

    // splash passthrough
    assert property (@(posedge video_clk) disable iff (btn_rst)
        (ok_q[1] && !game_q[1] && de_i) |-> rgb_i == spx_q[1])
    else begin
        $error("[FAIL] %0t rgb %h, splash pixel was %h", $time, $sampled(rgb_i),
               $sampled(spx_q[1]));
        failed = 1'b1;
    end

    assert property (@(posedge video_clk) disable iff (btn_rst)
        (ok_q[1] && game_q[1] && in_win2 && !blk_q[1]) |-> rgb_i == wide2)
    else begin
        $error("[FAIL] %0t rgb %h, widened game pixel %h", $time, $sampled(rgb_i),
               $sampled(wide2));
        failed = 1'b1;
    end

    assert property (@(posedge video_clk) disable iff (btn_rst)
        (ok_q[1] && game_q[1] && !in_win2) |-> rgb_i == '0)
    else begin
        $error("[FAIL] %0t rgb %h outside the window", $time, $sampled(rgb_i));
        failed = 1'b1;
    end

    assert property (@(posedge video_clk) disable iff (btn_rst)
        (ok_q[1] && game_q[1] && blk_q[1]) |-> rgb_i == '0)
    else begin
        $error("[FAIL] %0t rgb %h during blackout", $time, $sampled(rgb_i));
        failed = 1'b1;
    end

    // first cycle out of reset
    assert property (@(posedge video_clk) disable iff (btn_rst)
        rst_q |-> (!de_i && !hsync_i && !vsync_i && hdata_i == '0 && vdata_i == '0))
    else begin
        $error("[FAIL] %0t outputs not cleared after reset", $time);
        failed = 1'b1;
    end

endmodule

bind video_top video_top_asserts u_asserts (
    .video_clk      (video_clk),
    .btn_rst        (btn_rst),
    .start_i        (start_i),
    .to_black_i     (to_black_i),
    .game_pixel_i   (game_pixel_i),
    .splash_pixel_i (splash_pixel_i),
    .hdata_i        (hdata_o),
    .vdata_i        (vdata_o),
    .rgb_i          (rgb_o),
    .de_i           (de_o),
    .hsync_i        (hsync_o),
    .vsync_i        (vsync_o)
);

`default_nettype wire

/* sim/tb_video_top.sv */
`default_nettype none

module tb_video_top;
    timeunit 1ns;
    timeprecision 1ps;

    import video_pkg::*;

    localparam int unsigned wait_limit = int'(h_total) * int'(v_total) + int'(h_total);

    logic        video_clk;
    logic        btn_rst;
    logic        start_i;
    logic        to_black_i;
    rgb444_t     game_pixel_i;
    rgb888_t     splash_pixel_i;
    coord_t      hdata_o;
    coord_t      vdata_o;
    rgb888_t     rgb_o;
    logic        de_o;
    logic        hsync_o;
    logic        vsync_o;
    logic [31:0] rng_state;

    video_top dut_i (
        .video_clk      (video_clk),
        .btn_rst        (btn_rst),
        .start_i        (start_i),
        .to_black_i     (to_black_i),
        .game_pixel_i   (game_pixel_i),
        .splash_pixel_i (splash_pixel_i),
        .hdata_o        (hdata_o),
        .vdata_o        (vdata_o),
        .rgb_o          (rgb_o),
        .de_o           (de_o),
        .hsync_o        (hsync_o),
        .vsync_o        (vsync_o)
    );

    initial begin
        video_clk = 1'b0;
        forever #5 video_clk = ~video_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic wait_vsync_rise();
        int unsigned cycles;
        logic        last;
        logic        found;
        cycles = 0;
        found  = 1'b0;
        last   = vsync_o;
        while (!found && cycles < wait_limit) begin
            @(negedge video_clk);
            cycles++;
            found = vsync_o && !last;
            last  = vsync_o;
        end
        if (!found) begin
            abort_run("timeout while waiting for the vsync pulse");
        end
    endtask

    // returns on the falling edge where the line first shows
    task automatic wait_line(input coord_t line);
        int unsigned cycles;
        cycles = 0;
        while (vdata_o != line && cycles < wait_limit) begin
            @(negedge video_clk);
            cycles++;
        end
        if (vdata_o != line) begin
            abort_run($sformatf("timeout while waiting for line %0d", line));
        end
    endtask

    // new pixels from both sources every cycle
    always @(negedge video_clk) begin
        rng_state = xorshift32(rng_state);
        game_pixel_i = rng_state[11:0];
        rng_state = xorshift32(rng_state);
        splash_pixel_i = rng_state[23:0];
    end

    always @(negedge video_clk) begin
        if (dut_i.u_asserts.failed) begin
            abort_run("an assertion on video_top failed");
        end
    end

    initial begin
        rng_state      = 32'h8829b5fd;
        btn_rst        = 1'b1;
        start_i        = 1'b0;
        to_black_i     = 1'b0;
        game_pixel_i   = '0;
        splash_pixel_i = '0;
        repeat (3) @(negedge video_clk);
        btn_rst = 1'b0;

        wait_vsync_rise();  // splash frame done
        @(negedge video_clk);
        start_i = 1'b1;
        @(negedge video_clk);
        start_i = 1'b0;

        // game frame with a blacked out band
        wait_line(12'd200);
        to_black_i = 1'b1;
        wait_line(12'd260);
        to_black_i = 1'b0;
        wait_vsync_rise();

        wait_line(12'd320);
        btn_rst = 1'b1;
        repeat (3) @(negedge video_clk);
        btn_rst = 1'b0;
        wait_line(12'd2);
        repeat (pipe_latency + 1) @(negedge video_clk);

        if (dut_i.u_asserts.failed) begin
            abort_run("an assertion on video_top failed");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* project.f */
verilog/video_pkg.sv
verilog/video_timing.sv
verilog/pixel_compose.sv
verilog/video_out.sv
verilog/video_top.sv
sim/video_top_asserts.sv
sim/tb_video_top.sv

/* Bender.yml */
package:
  name: video_backend

sources:
  - verilog/video_pkg.sv
  - verilog/video_timing.sv
  - verilog/pixel_compose.sv
  - verilog/video_out.sv
  - verilog/video_top.sv
  - target: simulation
    files:
      - sim/video_top_asserts.sv
      - sim/tb_video_top.sv
